// ==== Bender.yml ====
package:
  name: ntt_agu

sources:
  - files:
      - source/ntt_agu_pkg.sv
      - source/ntt_cmd_latch.sv
      - source/ntt_stage_sequencer.sv
      - source/ntt_addr_map.sv
      - source/ntt_write_align.sv
      - source/ntt_agu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/ntt_agu_tb.sv

// ==== flist.f ====
+incdir+tests
source/ntt_agu_pkg.sv
source/ntt_cmd_latch.sv
source/ntt_stage_sequencer.sv
source/ntt_addr_map.sv
source/ntt_write_align.sv
source/ntt_agu_top.sv
tests/ntt_agu_tb.sv

// ==== source/ntt_addr_map.sv ====
`timescale 1ns/100ps

module ntt_addr_map (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    op_valid,
    input  ntt_agu_pkg::stage_t     op_stage,
    input  ntt_agu_pkg::bram_addr_t op_loop,
    input  ntt_agu_pkg::stage_t     run_global,
    output ntt_agu_pkg::bram_addr_t raddr,
    output logic                    ren,
    output ntt_agu_pkg::tw_addr_t   tw_addr,
    output ntt_agu_pkg::bram_addr_t even_addr,
    output ntt_agu_pkg::bram_addr_t odd_addr,
    output logic                    wr_valid,
    output logic                    bank_sel,
    output ntt_agu_pkg::stage_t     item_stage
);

    logic                    is_global;
    logic                    item_valid;
    ntt_agu_pkg::stage_t     k;
    ntt_agu_pkg::stage_t     k_up;
    ntt_agu_pkg::bram_addr_t base;
    ntt_agu_pkg::bram_addr_t half;
    ntt_agu_pkg::bram_addr_t group;
    ntt_agu_pkg::bram_addr_t loop_last;
    ntt_agu_pkg::tw_addr_t   stage_base;
    ntt_agu_pkg::tw_addr_t   cur_base;
    ntt_agu_pkg::tw_addr_t   base_step;

    // --------------------
    // data addresses
    // --------------------

    assign is_global = (op_stage < run_global);

    // butterfly span is 2^k words in a global stage
    assign k    = run_global - op_stage - 4'd1;
    assign k_up = k + 4'd1;
    assign base = (op_loop >> 1) + ((op_loop >> k_up) << k);
    assign half = ntt_agu_pkg::bram_addr_t'(1) << k;

    // --------------------
    // twiddle addresses
    // --------------------

    assign group     = is_global ? (op_loop >> k_up) : op_loop;
    assign loop_last = ~({ntt_agu_pkg::bram_aw{1'b1}} << run_global);

    // stage 0 always starts a new run at twiddle 0
    assign cur_base  = (op_stage == '0) ? '0 : stage_base;
    assign base_step = is_global ? (ntt_agu_pkg::tw_addr_t'(1) << op_stage)
                                 : ntt_agu_pkg::tw_addr_t'(loop_last) + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
            stage_base <= '0;
        end else begin
            item_valid <= op_valid;
            // advance on the last item of each stage
            if (op_valid && (op_loop == loop_last)) begin
                stage_base <= cur_base + base_step;
            end
        end
    end

    // address registers, all leave in the same cycle
    always_ff @(posedge clk) begin
        tw_addr    <= cur_base + ntt_agu_pkg::tw_addr_t'(group);
        bank_sel   <= op_loop[0];
        item_stage <= op_stage;
        if (is_global) begin
            raddr     <= op_loop[0] ? base + half : base;
            even_addr <= base;
            odd_addr  <= base + half;
        end else begin
            raddr     <= op_loop;
            even_addr <= op_loop;
            odd_addr  <= op_loop;
        end
    end

    assign ren      = item_valid;
    assign wr_valid = item_valid;

endmodule

// ==== source/ntt_agu_pkg.sv ====
package ntt_agu_pkg;

    // --------------------
    // transform constants
    // --------------------

    // log2 of the butterfly unit count
    localparam int pe_depth = 3;

    // supported polynomial sizes, as log2
    localparam int max_log_size = 12;
    localparam int min_log_size = 5;

    // --------------------
    // address widths
    // --------------------

    // up to 256 loops per stage
    localparam int bram_aw = 8;

    // up to 1279 twiddles over a full run
    localparam int tw_aw = 11;

    typedef logic [bram_aw-1:0] bram_addr_t;
    typedef logic [tw_aw-1:0]   tw_addr_t;

    // stage index, also wide enough for log_size
    typedef logic [3:0] stage_t;

    // extra butterfly latency
    typedef logic [1:0] delay_t;

    // sequencer states
    typedef enum logic [1:0] {
        idle,
        op,
        wait_gap
    } seq_state_t;

endpackage

// ==== source/ntt_agu_top.sv ====
`timescale 1ns/100ps

module ntt_agu_top #(
    parameter int wait_cycles = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  ntt_agu_pkg::stage_t     log_size,
    input  ntt_agu_pkg::delay_t     delay,
    output logic                    busy,
    output ntt_agu_pkg::bram_addr_t raddr,
    output logic                    ren,
    output ntt_agu_pkg::tw_addr_t   tw_addr,
    output ntt_agu_pkg::bram_addr_t waddr0,
    output logic                    wen0,
    output logic                    bank_sel0,
    output ntt_agu_pkg::bram_addr_t waddr1,
    output logic                    wen1,
    output logic                    bank_sel1,
    output ntt_agu_pkg::stage_t     stage_count,
    output logic                    done
);

    // --------------------
    // internal wires
    // --------------------

    logic                    go;
    logic                    last_done;
    ntt_agu_pkg::stage_t     run_log_size;
    ntt_agu_pkg::stage_t     run_global;
    ntt_agu_pkg::bram_addr_t run_loop_last;
    ntt_agu_pkg::delay_t     run_delay;
    logic                    op_valid;
    ntt_agu_pkg::stage_t     op_stage;
    ntt_agu_pkg::bram_addr_t op_loop;
    ntt_agu_pkg::bram_addr_t even_addr;
    ntt_agu_pkg::bram_addr_t odd_addr;
    logic                    wr_valid;
    logic                    bank_sel;
    ntt_agu_pkg::stage_t     item_stage;

    ntt_cmd_latch cmd_latch_i (
        .clk(clk), .reset(reset), .start(start), .log_size(log_size), .delay(delay),
        .last_done(last_done), .busy(busy), .go(go), .run_log_size(run_log_size),
        .run_global(run_global), .run_loop_last(run_loop_last), .run_delay(run_delay)
    );

    ntt_stage_sequencer #(.wait_cycles(wait_cycles)) sequencer_i (
        .clk(clk), .reset(reset), .go(go), .run_log_size(run_log_size),
        .run_loop_last(run_loop_last), .op_valid(op_valid), .op_stage(op_stage),
        .op_loop(op_loop), .last_done(last_done)
    );

    ntt_addr_map addr_map_i (
        .clk(clk), .reset(reset), .op_valid(op_valid), .op_stage(op_stage),
        .op_loop(op_loop), .run_global(run_global), .raddr(raddr), .ren(ren),
        .tw_addr(tw_addr), .even_addr(even_addr), .odd_addr(odd_addr),
        .wr_valid(wr_valid), .bank_sel(bank_sel), .item_stage(item_stage)
    );

    ntt_write_align write_align_i (
        .clk(clk), .reset(reset), .run_delay(run_delay), .even_addr(even_addr),
        .odd_addr(odd_addr), .wr_valid(wr_valid), .bank_sel(bank_sel),
        .item_stage(item_stage), .last_done(last_done), .waddr0(waddr0), .wen0(wen0),
        .bank_sel0(bank_sel0), .waddr1(waddr1), .wen1(wen1), .bank_sel1(bank_sel1),
        .stage_count(stage_count), .done(done)
    );

endmodule

// ==== source/ntt_cmd_latch.sv ====
`timescale 1ns/100ps

module ntt_cmd_latch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  ntt_agu_pkg::stage_t     log_size,
    input  ntt_agu_pkg::delay_t     delay,
    input  logic                    last_done,
    output logic                    busy,
    output logic                    go,
    output ntt_agu_pkg::stage_t     run_log_size,
    output ntt_agu_pkg::stage_t     run_global,
    output ntt_agu_pkg::bram_addr_t run_loop_last,
    output ntt_agu_pkg::delay_t     run_delay
);

    logic                accept;
    ntt_agu_pkg::stage_t global_cnt;

    // a start during a run is dropped
    assign accept = start && !busy;

    // stages whose butterflies span more than one memory word
    assign global_cnt = log_size - ntt_agu_pkg::stage_t'(ntt_agu_pkg::pe_depth + 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            go   <= 1'b0;
        end else begin
            go <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (last_done) begin
                busy <= 1'b0;
            end
        end
    end

    // per-run limits, loop_last is 2^global - 1
    always_ff @(posedge clk) begin
        if (accept) begin
            run_log_size  <= log_size;
            run_global    <= global_cnt;
            run_loop_last <= ~({ntt_agu_pkg::bram_aw{1'b1}} << global_cnt);
            run_delay     <= delay;
        end
    end

    a_log_size_range: assert property (@(posedge clk) disable iff (reset)
        accept |-> (log_size >= ntt_agu_pkg::min_log_size) &&
                   (log_size <= ntt_agu_pkg::max_log_size));

endmodule

// ==== source/ntt_stage_sequencer.sv ====
`timescale 1ns/100ps

module ntt_stage_sequencer #(
    parameter int wait_cycles = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    go,
    input  ntt_agu_pkg::stage_t     run_log_size,
    input  ntt_agu_pkg::bram_addr_t run_loop_last,
    output logic                    op_valid,
    output ntt_agu_pkg::stage_t     op_stage,
    output ntt_agu_pkg::bram_addr_t op_loop,
    output logic                    last_done
);

    localparam int wait_w = $clog2(wait_cycles);

    ntt_agu_pkg::seq_state_t state;
    ntt_agu_pkg::stage_t     stage_cnt;
    ntt_agu_pkg::bram_addr_t loop_cnt;
    logic [wait_w-1:0]       wait_cnt;
    logic                    loop_end;
    logic                    wait_end;
    logic                    final_stage;

    assign loop_end    = (loop_cnt == run_loop_last);
    assign wait_end    = (wait_cnt == wait_w'(wait_cycles - 1));
    assign final_stage = (stage_cnt == run_log_size - 4'd1);

    // --------------------
    // state and counters
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ntt_agu_pkg::idle;
            stage_cnt <= '0;
            loop_cnt  <= '0;
            wait_cnt  <= '0;
            last_done <= 1'b0;
        end else begin
            last_done <= 1'b0;
            case (state)
                ntt_agu_pkg::idle: begin
                    if (go) begin
                        state     <= ntt_agu_pkg::op;
                        stage_cnt <= '0;
                        loop_cnt  <= '0;
                    end
                end
                ntt_agu_pkg::op: begin
                    // one butterfly item per cycle
                    if (loop_end) begin
                        state    <= ntt_agu_pkg::wait_gap;
                        loop_cnt <= '0;
                        wait_cnt <= '0;
                    end else begin
                        loop_cnt <= loop_cnt + 1'b1;
                    end
                end
                ntt_agu_pkg::wait_gap: begin
                    // results of this stage feed the next one
                    if (wait_end) begin
                        if (final_stage) begin
                            state     <= ntt_agu_pkg::idle;
                            last_done <= 1'b1;
                        end else begin
                            state     <= ntt_agu_pkg::op;
                            stage_cnt <= stage_cnt + 4'd1;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ntt_agu_pkg::idle;
                end
            endcase
        end
    end

    // --------------------
    // operation item
    // --------------------

    assign op_valid = (state == ntt_agu_pkg::op);
    assign op_stage = stage_cnt;
    assign op_loop  = loop_cnt;

    a_op_in_range: assert property (@(posedge clk) disable iff (reset)
        op_valid |-> (op_loop <= run_loop_last) && (op_stage < run_log_size));

    // the command latch holds starts off while a run is active
    a_go_when_idle: assert property (@(posedge clk) disable iff (reset)
        go |-> (state == ntt_agu_pkg::idle));

endmodule

// ==== source/ntt_write_align.sv ====
`timescale 1ns/100ps

module ntt_write_align (
    input  logic                    clk,
    input  logic                    reset,
    input  ntt_agu_pkg::delay_t     run_delay,
    input  ntt_agu_pkg::bram_addr_t even_addr,
    input  ntt_agu_pkg::bram_addr_t odd_addr,
    input  logic                    wr_valid,
    input  logic                    bank_sel,
    input  ntt_agu_pkg::stage_t     item_stage,
    input  logic                    last_done,
    output ntt_agu_pkg::bram_addr_t waddr0,
    output logic                    wen0,
    output logic                    bank_sel0,
    output ntt_agu_pkg::bram_addr_t waddr1,
    output logic                    wen1,
    output logic                    bank_sel1,
    output ntt_agu_pkg::stage_t     stage_count,
    output logic                    done
);

    localparam int depth = 5;
    localparam int aw    = ntt_agu_pkg::bram_aw;
    localparam int dw    = 2 * aw + 1 + 4;

    logic [depth-1:0] valid_line;
    logic [depth-1:0] done_line;
    logic [dw-1:0]    data_line [depth];
    logic [dw-1:0]    even_word;
    logic [dw-1:0]    odd_word;
    logic [2:0]       even_tap;
    logic [2:0]       odd_tap;

    // odd lane lags the even lane by one butterfly cycle
    assign even_tap = {1'b0, run_delay};
    assign odd_tap  = even_tap + 3'd1;

    // --------------------
    // shift lines
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_line <= '0;
            done_line  <= '0;
        end else begin
            valid_line <= {valid_line[depth-2:0], wr_valid};
            done_line  <= {done_line[depth-2:0], last_done};
        end
    end

    always_ff @(posedge clk) begin
        data_line[0] <= {item_stage, bank_sel, odd_addr, even_addr};
        for (int i = 1; i < depth; i++) begin
            data_line[i] <= data_line[i-1];
        end
    end

    assign even_word = data_line[even_tap];
    assign odd_word  = data_line[odd_tap];

    // --------------------
    // output registers
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wen0 <= 1'b0;
            wen1 <= 1'b0;
            done <= 1'b0;
        end else begin
            wen0 <= valid_line[even_tap];
            wen1 <= valid_line[odd_tap];
            done <= done_line[odd_tap];
        end
    end

    always_ff @(posedge clk) begin
        waddr0      <= even_word[aw-1:0];
        bank_sel0   <= even_word[2*aw];
        waddr1      <= odd_word[2*aw-1:aw];
        bank_sel1   <= odd_word[2*aw];
        stage_count <= odd_word[dw-1 -: 4];
    end

    // no stale write may leak out of the line after a reset
    a_no_wen_after_reset: assert property (@(posedge clk)
        $past(reset, 2) |-> !wen0 && !wen1);

endmodule

// ==== tests/ntt_agu_checks.svh ====
`ifndef NTT_AGU_CHECKS_SVH
`define NTT_AGU_CHECKS_SVH

    // --------------------
    // fail path
    // --------------------

    task automatic stop_run();
        check_errors++;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // failures that are not a value mismatch
    task automatic fail_now(input string reason);
        $display("ERROR in %s: %s", test_name, reason);
        stop_run();
    endtask

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_addr(input string what, input ntt_agu_pkg::bram_addr_t exp,
                              input ntt_agu_pkg::bram_addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_tw(input string what, input ntt_agu_pkg::tw_addr_t exp,
                            input ntt_agu_pkg::tw_addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_stage(input string what, input ntt_agu_pkg::stage_t exp,
                               input ntt_agu_pkg::stage_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: %s expected %b actual %b", test_name, what, exp, act);
            stop_run();
        end
    endtask

    // cycle distances and totals
    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

`endif

// ==== tests/ntt_agu_tb.sv ====
`timescale 1ns/100ps

module ntt_agu_tb;

    logic                    clk;
    logic                    reset;
    logic                    start;
    ntt_agu_pkg::stage_t     log_size;
    ntt_agu_pkg::delay_t     delay;
    logic                    busy;
    ntt_agu_pkg::bram_addr_t raddr;
    logic                    ren;
    ntt_agu_pkg::tw_addr_t   tw_addr;
    ntt_agu_pkg::bram_addr_t waddr0;
    logic                    wen0;
    logic                    bank_sel0;
    ntt_agu_pkg::bram_addr_t waddr1;
    logic                    wen1;
    logic                    bank_sel1;
    ntt_agu_pkg::stage_t     stage_count;
    logic                    done;

    string  test_name;
    int     check_errors;
    int     cyc;
    int     gap_cycles;
    integer seed;

    // expected items in issue order
    ntt_agu_pkg::bram_addr_t exp_raddr[$];
    ntt_agu_pkg::tw_addr_t   exp_tw[$];
    ntt_agu_pkg::bram_addr_t exp_even[$];
    logic                    exp_even_bank[$];
    ntt_agu_pkg::bram_addr_t exp_odd[$];
    logic                    exp_odd_bank[$];
    ntt_agu_pkg::stage_t     exp_odd_stage[$];
    // cycles at which each pending write is due
    int                      even_due[$];
    int                      odd_due[$];

    `include "ntt_agu_checks.svh"

    ntt_agu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic step();
        @(negedge clk);
        cyc++;
    endtask

    // --------------------
    // reference model
    // --------------------

    task automatic build_expected(input int ls);
        int g;
        int loops;
        int k;
        int half;
        int base;
        int grp;
        int sbase;
        exp_raddr.delete();
        exp_tw.delete();
        exp_even.delete();
        exp_even_bank.delete();
        exp_odd.delete();
        exp_odd_bank.delete();
        exp_odd_stage.delete();
        even_due.delete();
        odd_due.delete();
        g = ls - ntt_agu_pkg::pe_depth - 1;
        loops = 1 << g;
        sbase = 0;
        for (int s = 0; s < ls; s++) begin
            for (int c = 0; c < loops; c++) begin
                if (s < g) begin
                    k = g - (s + 1);
                    half = 1 << k;
                    base = (c >> 1) + ((c >> (k + 1)) << k);
                    grp = c >> (g - s);
                    exp_raddr.push_back(
                        ntt_agu_pkg::bram_addr_t'((c % 2 == 1) ? base + half : base));
                    exp_even.push_back(ntt_agu_pkg::bram_addr_t'(base));
                    exp_odd.push_back(ntt_agu_pkg::bram_addr_t'(base + half));
                end else begin
                    grp = c;
                    exp_raddr.push_back(ntt_agu_pkg::bram_addr_t'(c));
                    exp_even.push_back(ntt_agu_pkg::bram_addr_t'(c));
                    exp_odd.push_back(ntt_agu_pkg::bram_addr_t'(c));
                end
                exp_tw.push_back(ntt_agu_pkg::tw_addr_t'(sbase + grp));
                exp_even_bank.push_back((c % 2) == 1);
                exp_odd_bank.push_back((c % 2) == 1);
                exp_odd_stage.push_back(ntt_agu_pkg::stage_t'(s));
            end
            sbase += (s < g) ? (1 << s) : loops;
        end
    endtask

    // --------------------
    // one run and scoreboard
    // --------------------

    task automatic run_test(input int ls, input int dl, input int exp_reads,
                            input int exp_last_tw, input int restart);
        int start_cyc;
        int reads;
        int loops;
        int low_run;
        int last_busy;
        int last_odd;
        int limit;
        int n;
        logic seen_done;
        logic injected;
        ntt_agu_pkg::tw_addr_t last_tw;
        build_expected(ls);
        limit = exp_reads + ls * (gap_cycles + 2) + 40;
        loops = 1 << (ls - ntt_agu_pkg::pe_depth - 1);
        start = 1'b1;
        log_size = ntt_agu_pkg::stage_t'(ls);
        delay = ntt_agu_pkg::delay_t'(dl);
        start_cyc = cyc;
        reads = 0;
        low_run = 0;
        last_busy = cyc;
        last_odd = 0;
        n = 0;
        seen_done = 1'b0;
        injected = 1'b0;
        last_tw = '0;
        while (!seen_done) begin
            step();
            n++;
            if (n > limit) fail_now("timeout waiting for done");
            start = 1'b0;
            if (busy) last_busy = cyc;
            if (ren) begin
                if (exp_raddr.size() == 0) fail_now("read issued beyond the expected count");
                if (reads == 0) begin
                    check_count("first read latency", 3, cyc - start_cyc);
                end else if (reads % loops == 0) begin
                    check_count("ren gap between stages", gap_cycles, low_run);
                end else begin
                    check_count("ren gap inside a stage", 0, low_run);
                end
                check_addr("read address", exp_raddr.pop_front(), raddr);
                check_tw("twiddle address", exp_tw.pop_front(), tw_addr);
                even_due.push_back(cyc + dl + 2);
                odd_due.push_back(cyc + dl + 3);
                last_tw = tw_addr;
                reads++;
                low_run = 0;
            end else if (reads > 0) begin
                low_run++;
            end
            if (wen0) begin
                if (even_due.size() == 0) fail_now("even-lane write without a matching read");
                check_count("even write cycle", even_due.pop_front(), cyc);
                check_addr("even write address", exp_even.pop_front(), waddr0);
                check_bit("even bank select", exp_even_bank.pop_front(), bank_sel0);
            end
            if (wen1) begin
                if (odd_due.size() == 0) fail_now("odd-lane write without a matching read");
                check_count("odd write cycle", odd_due.pop_front(), cyc);
                check_addr("odd write address", exp_odd.pop_front(), waddr1);
                check_bit("odd bank select", exp_odd_bank.pop_front(), bank_sel1);
                check_stage("stage count", exp_odd_stage.pop_front(), stage_count);
                last_odd = cyc;
            end
            if (done) begin
                seen_done = 1'b1;
                check_count("read count", exp_reads, reads);
                check_tw("final twiddle address", ntt_agu_pkg::tw_addr_t'(exp_last_tw), last_tw);
                check_count("even writes left", 0, exp_even.size());
                check_count("odd writes left", 0, exp_odd.size());
                check_count("last busy cycle to done", dl + 3, cyc - last_busy);
                if (last_odd == 0 || last_odd >= cyc) begin
                    fail_now("done came before the last odd write");
                end
            end
            // a second start in the middle of the run must be dropped
            if (restart != 0 && !injected && reads == exp_reads / 2) begin
                check_bit("busy at extra start", 1'b1, busy);
                start = 1'b1;
                log_size = ntt_agu_pkg::stage_t'(ntt_agu_pkg::min_log_size +
                                                 ($unsigned($random(seed)) % 8));
                delay = ntt_agu_pkg::delay_t'($random(seed));
                injected = 1'b1;
            end
        end
        // quiet tail where done must not pulse again
        repeat (gap_cycles + 8) begin
            step();
            check_bit("done after run", 1'b0, done);
            check_bit("ren after run", 1'b0, ren);
            check_bit("wen0 after run", 1'b0, wen0);
            check_bit("wen1 after run", 1'b0, wen1);
            check_bit("busy after run", 1'b0, busy);
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    runs;
        int    ls;
        int    dl;
        int    reads;
        int    tw;
        int    rs;
        string line;
        string name;
        reset = 1'b1;
        start = 1'b0;
        log_size = ntt_agu_pkg::stage_t'(ntt_agu_pkg::min_log_size);
        delay = '0;
        check_errors = 0;
        cyc = 0;
        runs = 0;
        seed = 32'h9632_cfa7;
        test_name = "reset";
        gap_cycles = dut_i.wait_cycles;
        repeat (3) @(posedge clk);
        step();
        reset = 1'b0;

        test_name = "idle_after_reset";
        repeat (20) begin
            step();
            check_bit("busy", 1'b0, busy);
            check_bit("ren", 1'b0, ren);
            check_bit("wen0", 1'b0, wen0);
            check_bit("wen1", 1'b0, wen1);
            check_bit("done", 1'b0, done);
        end

        fd = $fopen("tests/ntt_agu_tests.txt", "r");
        if (fd == 0) fail_now("cannot open tests/ntt_agu_tests.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            code = $sscanf(line, "%s %d %d %d %d %d", name, ls, dl, reads, tw, rs);
            if (code != 6) fail_now("malformed line in the test data file");
            test_name = name;
            run_test(ls, dl, reads, tw, rs);
            runs++;
        end
        $fclose(fd);
        test_name = "summary";
        if (runs == 0) fail_now("no runs found in the test data file");

        if (check_errors == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== tests/ntt_agu_tests.txt ====
# name log_size delay expected_reads expected_final_twiddle restart_while_busy
# reads = log_size * 2^(log_size-4), final twiddle = 5 * 2^(log_size-4) - 2
size5_d0 5 0 10 8 0
size5_d1 5 1 10 8 0
size6_d3 6 3 24 18 0
size7_d2 7 2 56 38 0
size8_d0 8 0 128 78 0
size8_d1 8 1 128 78 0
size8_d2 8 2 128 78 0
size8_d3 8 3 128 78 0
size9_d1 9 1 288 158 0
size10_d0 10 0 640 318 0
size11_d3 11 3 1408 638 0
size12_d2 12 2 3072 1278 0
size12_d3 12 3 3072 1278 0
restart5_d3 5 3 10 8 1
restart8_d2 8 2 128 78 1
restart12_d0 12 0 3072 1278 1
size5_d2 5 2 10 8 0
size6_d0 6 0 24 18 0
